//--- core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

////////////////////////////////////////
// Link widths

// Host to FPGA
`define PC_IN_W 24
// FPGA to chip
`define BD_OUT_W 22
// Chip to FPGA
`define BD_IN_W 34
// FPGA to host
`define PC_OUT_W 40

////////////////////////////////////////
// Core sizes

`define TIME_W 32
`define CONF_W 16
`define NUM_REGS 8
`define NUM_GENS 4

////////////////////////////////////////
// Word codes

// Route field of a spike word, bits 21..19
`define SPIKE_ROUTE 3'd7
// Host word codes, bits 39..38
`define PC_CODE_BD 2'd0
`define PC_CODE_HB 2'd1

`endif

//--- corePkg.sv
`default_nettype none

`include "core_params.svh"

package corePkg;

  ////////////////////////////////////////
  // Link words

  typedef logic [`PC_IN_W-1:0] pcWord_t;
  typedef logic [`BD_OUT_W-1:0] bdOutWord_t;
  typedef logic [`BD_IN_W-1:0] bdInWord_t;
  typedef logic [`PC_OUT_W-1:0] pcOutWord_t;

  // Elapsed time in units
  typedef logic [`TIME_W-1:0] timeVal_t;

  // Register file
  typedef logic [`CONF_W-1:0] confWord_t;
  typedef logic [$clog2(`NUM_REGS)-1:0] confAddr_t;

  // Spike generators
  typedef logic [7:0] spikeTag_t;
  typedef logic [$clog2(`NUM_GENS)-1:0] genIdx_t;

  ////////////////////////////////////////
  // Channels, ack runs separately

  typedef struct packed {
    logic    valid;
    pcWord_t data;
  } pcInChan_t;

  typedef struct packed {
    logic       valid;
    bdOutWord_t data;
  } bdOutChan_t;

  typedef struct packed {
    logic      valid;
    bdInWord_t data;
  } bdInChan_t;

  typedef struct packed {
    logic       valid;
    pcOutWord_t data;
  } pcOutChan_t;

  ////////////////////////////////////////
  // Decoded register file

  typedef struct packed {
    // Reg 0, clocks per unit, 0 stops time
    confWord_t                      timeUnitCycles;
    // Reg 1, units per heartbeat, 0 disables
    confWord_t                      heartbeatUnits;
    // Reg 2 bit 0
    logic                           stallDn;
    // Reg 3 low bits
    logic [`NUM_GENS-1:0]           genEnable;
    // Regs 4..7 low byte
    logic [`NUM_GENS-1:0][7:0]      genPeriod;
    // Regs 4..7 high byte
    spikeTag_t [`NUM_GENS-1:0]      genTag;
  } coreConf_t;

endpackage

`default_nettype wire

//--- pcParser.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module pcParser
  import corePkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  pcInChan_t  pcIn,
  output logic       pcInAck,
  output bdOutChan_t parserBd,
  input  logic       parserBdAck,
  output coreConf_t  conf
);

  // Register file, all zero after reset
  confWord_t [`NUM_REGS-1:0] regs;

  // One-word chip output register
  logic       bdFull;
  bdOutWord_t bdWord;

  logic      isConf;
  logic      accept;
  confAddr_t wrAddr;

  ////////////////////////////////////////
  // Host word decode

  // Top bit selects config write
  assign isConf = pcIn.data[`PC_IN_W-1];
  assign wrAddr = confAddr_t'(pcIn.data[18:16]);

  // Config writes never stall
  // Chip words need room in the output register
  assign pcInAck = isConf | ~bdFull | parserBdAck;
  assign accept  = pcIn.valid & pcInAck;

  always_ff @(posedge clk) begin
    if (reset) begin
      regs   <= '0;
      bdFull <= 1'b0;
    end else begin
      if (accept && isConf)
        regs[wrAddr] <= pcIn.data[`CONF_W-1:0];
      // New word replaces an acked one in the same cycle
      if (accept && !isConf)
        bdFull <= 1'b1;
      else if (parserBdAck)
        bdFull <= 1'b0;
    end
  end

  // Chip word payload
  always_ff @(posedge clk) begin
    if (accept && !isConf)
      bdWord <= pcIn.data[`BD_OUT_W-1:0];
  end

  always_comb begin
    parserBd.valid = bdFull;
    parserBd.data  = bdWord;
  end

  ////////////////////////////////////////
  // Register map

  always_comb begin
    conf.timeUnitCycles = regs[0];
    conf.heartbeatUnits = regs[1];
    conf.stallDn        = regs[2][0];
    conf.genEnable      = regs[3][`NUM_GENS-1:0];
    // One register per generator from 4 up
    for (int g = 0; g < `NUM_GENS; g++) begin
      conf.genPeriod[g] = regs[4+g][7:0];
      conf.genTag[g]    = regs[4+g][15:8];
    end
  end

endmodule

`default_nettype wire

//--- timeMgr.sv
`timescale 1ns/1ps
`default_nettype none

module timeMgr
  import corePkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  coreConf_t conf,
  output logic      unitPulse,
  output logic      hbPulse,
  output timeVal_t  timeElapsed
);

  // Clock counter within one unit
  confWord_t unitCnt;
  // Last seen reg 0, a change restarts the unit
  confWord_t unitPrev;
  // Units since last heartbeat
  confWord_t hbCnt;

  logic unitRestart;

  ////////////////////////////////////////
  // Pulses

  assign unitRestart = conf.timeUnitCycles != unitPrev;

  // Last clock of a unit
  assign unitPulse = (conf.timeUnitCycles != '0) && !unitRestart &&
                     (unitCnt == conf.timeUnitCycles - 1'b1);

  // Every H-th unit, also catches a shrunk H
  assign hbPulse = unitPulse && (conf.heartbeatUnits != '0) &&
                   (hbCnt >= conf.heartbeatUnits - 1'b1);

  ////////////////////////////////////////
  // Counters

  always_ff @(posedge clk) begin
    if (reset) begin
      unitCnt     <= '0;
      unitPrev    <= '0;
      hbCnt       <= '0;
      timeElapsed <= '0;
    end else begin
      unitPrev <= conf.timeUnitCycles;
      if (unitRestart || unitPulse)
        unitCnt <= '0;
      else if (conf.timeUnitCycles != '0)
        unitCnt <= unitCnt + 1'b1;
      if (unitPulse)
        timeElapsed <= timeElapsed + 1'b1;
      // Held at zero while heartbeats are off
      if (conf.heartbeatUnits == '0)
        hbCnt <= '0;
      else if (hbPulse)
        hbCnt <= '0;
      else if (unitPulse)
        hbCnt <= hbCnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- spikeGenArray.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module spikeGenArray
  import corePkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  coreConf_t  conf,
  input  logic       unitPulse,
  output bdOutChan_t spikeBd,
  input  logic       spikeBdAck
);

  // Units counted per generator
  logic [`NUM_GENS-1:0][7:0] genCnt;
  // Spike waiting for the output
  logic [`NUM_GENS-1:0]      pending;
  // Period reached this cycle
  logic [`NUM_GENS-1:0]      fire;

  genIdx_t winIdx;
  logic    spikeTaken;

  ////////////////////////////////////////
  // Period match

  always_comb begin
    for (int g = 0; g < `NUM_GENS; g++) begin
      // Zero period never fires
      fire[g] = conf.genEnable[g] && unitPulse &&
                (conf.genPeriod[g] != 8'd0) &&
                (genCnt[g] + 8'd1 == conf.genPeriod[g]);
    end
  end

  ////////////////////////////////////////
  // Lowest-index arbitration

  always_comb begin
    winIdx = '0;
    // Scan down so index 0 wins last
    for (int g = `NUM_GENS - 1; g >= 0; g--) begin
      if (pending[g])
        winIdx = genIdx_t'(g);
    end
  end

  assign spikeTaken = spikeBd.valid & spikeBdAck;

  // Route, zero field, index, tag
  always_comb begin
    spikeBd.valid = |pending;
    spikeBd.data  = {`SPIKE_ROUTE, 9'd0, winIdx, conf.genTag[winIdx]};
  end

  ////////////////////////////////////////
  // Counters and pending flags

  always_ff @(posedge clk) begin
    if (reset) begin
      genCnt  <= '0;
      pending <= '0;
    end else begin
      for (int g = 0; g < `NUM_GENS; g++) begin
        if (spikeTaken && (winIdx == genIdx_t'(g)))
          pending[g] <= 1'b0;
        // Disabled generator restarts from zero
        if (!conf.genEnable[g]) begin
          genCnt[g] <= 8'd0;
        end else if (fire[g]) begin
          genCnt[g]  <= 8'd0;
          // Overrides the clear, a second firing merges
          pending[g] <= 1'b1;
        end else if (unitPulse) begin
          genCnt[g] <= genCnt[g] + 8'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- bdOutMerge.sv
`timescale 1ns/1ps
`default_nettype none

module bdOutMerge
  import corePkg::*;
(
  input  bdOutChan_t parserBd,
  output logic       parserBdAck,
  input  bdOutChan_t spikeBd,
  output logic       spikeBdAck,
  input  coreConf_t  conf,
  output bdOutChan_t bdOut,
  input  logic       bdOutAck
);

  logic stall;
  logic pickParser;
  // Output ack seen by the sources
  logic passAck;

  ////////////////////////////////////////
  // Source select

  assign stall = conf.stallDn;

  // Host words have fixed priority
  assign pickParser = parserBd.valid;

  always_comb begin
    // Stall hides both sources from the chip
    bdOut.valid = (parserBd.valid | spikeBd.valid) & ~stall;
    bdOut.data  = pickParser ? parserBd.data : spikeBd.data;
  end

  ////////////////////////////////////////
  // Ack steering

  // Nothing moves while stalled
  assign passAck = bdOutAck & ~stall;

  // Only the chosen source sees the ack
  assign parserBdAck = passAck & pickParser;
  assign spikeBdAck  = passAck & ~pickParser & spikeBd.valid;

endmodule

`default_nettype wire

//--- pcPacker.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module pcPacker
  import corePkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  bdInChan_t  bdIn,
  output logic       bdInAck,
  input  logic       hbPulse,
  input  timeVal_t   timeElapsed,
  output pcOutChan_t pcOut,
  input  logic       pcOutAck
);

  // What the output register holds
  typedef enum logic [1:0] {
    empty,
    holdBd,
    holdHb
  } packState_t;

  packState_t state;

  // Heartbeat request and its time
  logic       hbPending;
  timeVal_t   hbTime;
  pcOutWord_t outWord;

  logic loadOk;
  logic takeHb;
  logic takeBd;

  ////////////////////////////////////////
  // Load control

  // Register free or leaving this edge
  assign loadOk = (state == empty) | pcOutAck;

  // Heartbeat beats a chip word
  assign takeHb  = loadOk & hbPending;
  assign takeBd  = loadOk & ~hbPending & bdIn.valid;
  assign bdInAck = loadOk & ~hbPending;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= empty;
      hbPending <= 1'b0;
    end else begin
      if (loadOk) begin
        if (takeHb)
          state <= holdHb;
        else if (takeBd)
          state <= holdBd;
        else
          state <= empty;
      end
      // New pulse merges into a pending one
      if (hbPulse)
        hbPending <= 1'b1;
      else if (takeHb)
        hbPending <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Payload and formatting

  always_ff @(posedge clk) begin
    // Latest pulse time wins
    if (hbPulse)
      hbTime <= timeElapsed;
    // Code on top, data zero padded below
    if (takeHb) begin
      outWord                    <= pcOutWord_t'(hbTime);
      outWord[`PC_OUT_W-1 -: 2]  <= `PC_CODE_HB;
    end else if (takeBd) begin
      outWord                    <= pcOutWord_t'(bdIn.data);
      outWord[`PC_OUT_W-1 -: 2]  <= `PC_CODE_BD;
    end
  end

  always_comb begin
    pcOut.valid = (state == holdBd) || (state == holdHb);
    pcOut.data  = outWord;
  end

endmodule

`default_nettype wire

//--- core.sv
`timescale 1ns/1ps
`default_nettype none

module core
  import corePkg::*;
(
  input  logic       clk,
  input  logic       reset,
  // Host side
  input  pcInChan_t  pcIn,
  output logic       pcInAck,
  output pcOutChan_t pcOut,
  input  logic       pcOutAck,
  // Chip side
  output bdOutChan_t bdOut,
  input  logic       bdOutAck,
  input  bdInChan_t  bdIn,
  output logic       bdInAck
);

  ////////////////////////////////////////
  // Internal nets

  coreConf_t  conf;
  bdOutChan_t parserBd;
  logic       parserBdAck;
  bdOutChan_t spikeBd;
  logic       spikeBdAck;
  logic       unitPulse;
  logic       hbPulse;
  timeVal_t   timeElapsed;

  ////////////////////////////////////////
  // Config and time

  pcParser i_pcParser (
    .clk         (clk),
    .reset       (reset),
    .pcIn        (pcIn),
    .pcInAck     (pcInAck),
    .parserBd    (parserBd),
    .parserBdAck (parserBdAck),
    .conf        (conf)
  );

  timeMgr i_timeMgr (
    .clk         (clk),
    .reset       (reset),
    .conf        (conf),
    .unitPulse   (unitPulse),
    .hbPulse     (hbPulse),
    .timeElapsed (timeElapsed)
  );

  ////////////////////////////////////////
  // Host to chip

  spikeGenArray i_spikeGenArray (
    .clk        (clk),
    .reset      (reset),
    .conf       (conf),
    .unitPulse  (unitPulse),
    .spikeBd    (spikeBd),
    .spikeBdAck (spikeBdAck)
  );

  bdOutMerge i_bdOutMerge (
    .parserBd    (parserBd),
    .parserBdAck (parserBdAck),
    .spikeBd     (spikeBd),
    .spikeBdAck  (spikeBdAck),
    .conf        (conf),
    .bdOut       (bdOut),
    .bdOutAck    (bdOutAck)
  );

  ////////////////////////////////////////
  // Chip to host

  pcPacker i_pcPacker (
    .clk         (clk),
    .reset       (reset),
    .bdIn        (bdIn),
    .bdInAck     (bdInAck),
    .hbPulse     (hbPulse),
    .timeElapsed (timeElapsed),
    .pcOut       (pcOut),
    .pcOutAck    (pcOutAck)
  );

endmodule

`default_nettype wire

//--- core_sva.sv
`timescale 1ns/1ps
`default_nettype none

module coreSva
  import corePkg::*;
(
  input logic       clk,
  input logic       reset,
  input pcOutChan_t pcOut,
  input logic       pcOutAck,
  input bdOutChan_t bdOut,
  input logic       bdOutAck,
  input coreConf_t  conf
);

  // Failed assertions so far
  int failCount = 0;

  ////////////////////////////////////////
  // Reset

  // Quiet once reset has held for an edge
  resetQuiet: assert property (@(posedge clk)
      reset && $past(reset) |-> !bdOut.valid && !pcOut.valid)
    else begin
      failCount++;
      $error("valid output high during reset");
    end

  ////////////////////////////////////////
  // Channel rules

  bdHold: assert property (@(posedge clk) disable iff (reset)
      bdOut.valid && !bdOutAck |=> bdOut.valid && $stable(bdOut.data))
    else begin
      failCount++;
      $error("bdOut word dropped or changed before ack");
    end

  pcHold: assert property (@(posedge clk) disable iff (reset)
      pcOut.valid && !pcOutAck |=> pcOut.valid && $stable(pcOut.data))
    else begin
      failCount++;
      $error("pcOut word dropped or changed before ack");
    end

  // Stall hides the chip output
  stallQuiet: assert property (@(posedge clk) disable iff (reset)
      conf.stallDn |-> !bdOut.valid)
    else begin
      failCount++;
      $error("bdOut valid while stall is set");
    end

endmodule

bind core coreSva i_coreSva (
  .clk      (clk),
  .reset    (reset),
  .pcOut    (pcOut),
  .pcOutAck (pcOutAck),
  .bdOut    (bdOut),
  .bdOutAck (bdOutAck),
  .conf     (conf)
);

`default_nettype wire

//--- coreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

// Free-running 20 ns clock
module tbClock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

endmodule

module coreTb
  import corePkg::*;
();

  // Wait selectors
  localparam int BdDrained  = 0;
  localparam int PcDrained  = 1;
  localparam int SpikesSeen = 2;
  localparam int HbsSeen    = 3;
  // Spike and heartbeat setup
  localparam int SpikeUnit   = 3;
  localparam int SpikePeriod = 4;
  localparam int HbUnits     = 5;

  logic       clk;
  logic       reset    = 1'b1;
  pcInChan_t  pcIn     = '0;
  logic       pcInAck;
  pcOutChan_t pcOut;
  logic       pcOutAck = 1'b0;
  bdOutChan_t bdOut;
  logic       bdOutAck = 1'b0;
  bdInChan_t  bdIn     = '0;
  logic       bdInAck;

  integer seed      = 32'hd4d3_1e4e;
  bit     randBdAck = 1'b1;
  bit     randPcAck = 1'b1;

  // Reference queues with the oldest word first
  bdOutWord_t bdQueue[$];
  pcOutWord_t pcQueue[$];

  string testName    = "reset";
  int    checkErrors = 0;
  int    timeouts    = 0;
  int    cycle       = 0;
  // Spike tracking
  bit         spikeAllowed = 1'b0;
  bdOutWord_t expSpike     = '0;
  int         expGap       = 0;
  int         lastSpike    = -1;
  int         spikeCount   = 0;
  // Heartbeat tracking
  bit       hbAllowed  = 1'b0;
  bit       hbSeen     = 1'b0;
  timeVal_t lastHbTime = '0;
  int       hbCount    = 0;

  tbClock i_tbClock (.clk(clk));

  core i_core (
    .clk      (clk),
    .reset    (reset),
    .pcIn     (pcIn),
    .pcInAck  (pcInAck),
    .pcOut    (pcOut),
    .pcOutAck (pcOutAck),
    .bdOut    (bdOut),
    .bdOutAck (bdOutAck),
    .bdIn     (bdIn),
    .bdInAck  (bdInAck)
  );

  ////////////////////////////////////////
  // Reporting

  task automatic reportMismatch(input logic [63:0] exp, input logic [63:0] act);
    checkErrors++;
    $display("ERROR %s: expected %0h, actual %0h", testName, exp, act);
  endtask

  task automatic reportFault(input string what);
    checkErrors++;
    $display("ERROR %s: %s", testName, what);
  endtask

  task automatic noteTimeout(input string what);
    timeouts++;
    $display("ERROR %s: timed out waiting for %s", testName, what);
  endtask

  ////////////////////////////////////////
  // Stimulus

  // Random chip word with the route field off the spike code
  function automatic pcWord_t hostWord();
    logic [31:0] r;
    r = $random(seed);
    // Bit 19 cleared only where the route would read as a spike
    if (r[21:19] == `SPIKE_ROUTE)
      r[19] = 1'b0;
    return {2'b00, r[21:0]};
  endfunction

  function automatic bdInWord_t chipWord();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[`BD_IN_W-1:0];
  endfunction

  task automatic sendHost(input pcWord_t word);
    bit ok;
    @(negedge clk);
    pcIn.valid = 1'b1;
    pcIn.data  = word;
    ok = 1'b0;
    for (int n = 0; n < 200 && !ok; n++) begin
      @(posedge clk);
      ok = pcInAck;
    end
    @(negedge clk);
    pcIn.valid = 1'b0;
    if (!ok)
      noteTimeout("pcInAck");
    else if (!word[`PC_IN_W-1])
      bdQueue.push_back(word[`BD_OUT_W-1:0]);
  endtask

  // Config write has the top bit set
  task automatic writeReg(input confAddr_t addr, input confWord_t value);
    sendHost({1'b1, 4'd0, addr, value});
  endtask

  task automatic sendChip(input bdInWord_t word);
    bit ok;
    @(negedge clk);
    bdIn.valid = 1'b1;
    bdIn.data  = word;
    ok = 1'b0;
    for (int n = 0; n < 200 && !ok; n++) begin
      @(posedge clk);
      ok = bdInAck;
    end
    @(negedge clk);
    bdIn.valid = 1'b0;
    // Code, zero pad, then the chip word
    if (!ok)
      noteTimeout("bdInAck");
    else
      pcQueue.push_back({`PC_CODE_BD, 4'd0, word});
  endtask

  function automatic bit reached(input int what);
    case (what)
      BdDrained:  return bdQueue.size() == 0;
      PcDrained:  return pcQueue.size() == 0;
      SpikesSeen: return spikeCount >= 5;
      default:    return hbCount >= 4;
    endcase
  endfunction

  task automatic waitFor(input int what, input string label);
    int n;
    n = 0;
    while (!reached(what) && n < 500) begin
      @(negedge clk);
      n++;
    end
    if (!reached(what))
      noteTimeout(label);
  endtask

  // Far-end acks stay high while timing is checked
  always @(negedge clk) begin
    bdOutAck = randBdAck ? 1'($random(seed)) : 1'b1;
    pcOutAck = randPcAck ? 1'($random(seed)) : 1'b1;
  end

  ////////////////////////////////////////
  // Output monitor

  always @(posedge clk) begin
    bdOutWord_t bdExp;
    pcOutWord_t pcExp;
    cycle++;
    if (!reset && bdOut.valid && bdOutAck) begin
      if (bdOut.data[`BD_OUT_W-1 -: 3] == `SPIKE_ROUTE) begin
        assert (spikeAllowed) else reportFault("spike word without configuration");
        assert (bdOut.data == expSpike) else reportMismatch(expSpike, bdOut.data);
        if (lastSpike >= 0) begin
          assert (cycle - lastSpike == expGap) else reportMismatch(expGap, cycle - lastSpike);
        end
        lastSpike = cycle;
        spikeCount++;
      end else if (bdQueue.size() == 0) begin
        reportFault("unexpected word on bdOut");
      end else begin
        bdExp = bdQueue.pop_front();
        assert (bdOut.data == bdExp) else reportMismatch(bdExp, bdOut.data);
      end
    end
    if (!reset && pcOut.valid && pcOutAck) begin
      if (pcOut.data[`PC_OUT_W-1 -: 2] == `PC_CODE_HB) begin
        assert (hbAllowed) else reportFault("heartbeat without configuration");
        // Time steps by H units per heartbeat
        pcExp = {`PC_CODE_HB, 6'd0, lastHbTime + timeVal_t'(HbUnits)};
        if (hbSeen) begin
          assert (pcOut.data == pcExp) else reportMismatch(pcExp, pcOut.data);
        end
        lastHbTime = pcOut.data[`TIME_W-1:0];
        hbSeen     = 1'b1;
        hbCount++;
      end else if (pcQueue.size() == 0) begin
        reportFault("unexpected word on pcOut");
      end else begin
        pcExp = pcQueue.pop_front();
        assert (pcOut.data == pcExp) else reportMismatch(pcExp, pcOut.data);
      end
    end
  end

  // Zero padding below the code
  padZero: assert property (@(posedge clk) disable iff (reset)
      pcOut.valid |-> pcOut.data[37:34] == 4'd0)
    else reportMismatch(0, $sampled(pcOut.data[37:34]));

  // Spike words keep their middle field clear
  spikeShape: assert property (@(posedge clk) disable iff (reset)
      bdOut.valid && bdOut.data[21:19] == `SPIKE_ROUTE |-> bdOut.data[18:10] == 9'd0)
    else reportMismatch(0, $sampled(bdOut.data[18:10]));

  ////////////////////////////////////////
  // Test sequence

  initial begin
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Nothing comes out before configuration
    for (int i = 0; i < 40; i++) begin
      @(negedge clk);
      assert (!bdOut.valid && !pcOut.valid) else reportFault("valid output before configuration");
    end

    testName = "hostOrder";
    for (int i = 0; i < 20; i++)
      sendHost(hostWord());
    waitFor(BdDrained, "host words on bdOut");

    // One word parked behind the stall
    testName = "stall";
    writeReg(3'd2, 16'd1);
    sendHost(hostWord());
    for (int i = 0; i < 30; i++) begin
      @(negedge clk);
      assert (!bdOut.valid) else reportFault("bdOut valid while stalled");
    end
    assert (bdQueue.size() == 1) else reportMismatch(1, bdQueue.size());
    writeReg(3'd2, 16'd0);
    for (int i = 0; i < 3; i++)
      sendHost(hostWord());
    waitFor(BdDrained, "stalled words on bdOut");

    // Only generator 0 with tag a5
    testName     = "spike";
    randBdAck    = 1'b0;
    expSpike     = {`SPIKE_ROUTE, 9'd0, 2'd0, 8'ha5};
    expGap       = SpikePeriod * SpikeUnit;
    spikeAllowed = 1'b1;
    writeReg(3'd0, confWord_t'(SpikeUnit));
    writeReg(3'd4, {8'ha5, 8'(SpikePeriod)});
    writeReg(3'd3, 16'd1);
    waitFor(SpikesSeen, "spike words");
    writeReg(3'd3, 16'd0);
    repeat (20) @(negedge clk);
    spikeAllowed = 1'b0;
    randBdAck    = 1'b1;

    testName  = "heartbeat";
    randPcAck = 1'b0;
    hbAllowed = 1'b1;
    writeReg(3'd1, confWord_t'(HbUnits));
    waitFor(HbsSeen, "heartbeat words");
    writeReg(3'd1, 16'd0);
    writeReg(3'd0, 16'd0);
    repeat (20) @(negedge clk);
    hbAllowed = 1'b0;
    randPcAck = 1'b1;

    // Chip words only while time is stopped
    testName = "chipOrder";
    for (int i = 0; i < 20; i++)
      sendChip(chipWord());
    waitFor(PcDrained, "chip words on pcOut");

    $display("Errors: %0d failed checks, %0d timeouts, %0d failed assertions",
             checkErrors, timeouts, i_core.i_coreSva.failCount);
    if (checkErrors + timeouts + i_core.i_coreSva.failCount == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // Hard stop for a stuck run
  initial begin
    repeat (20000) @(posedge clk);
    $display("Simulation limit reached before the tests finished");
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
corePkg.sv
pcParser.sv
timeMgr.sv
spikeGenArray.sv
bdOutMerge.sv
pcPacker.sv
core.sv
core_sva.sv
coreTb.sv

//--- Makefile
SIM       = verilator
TOP       = coreTb
FILELIST  = src.f
FLAGS     = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
RUNFLAGS  = +verilator+error+limit+1000
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) 2>&1 | tee $(LOG)
	grep -qx "Done: no errors" $(LOG)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
